//--- verilog.f
+incdir+tb
design/versat_geom_pkg.sv
design/versat_fu_pkg.sv
design/xmem.sv
design/xalu.sv
design/xaddr_gen.sv
design/xrun_ctrl.sv
design/xconf_regs.sv
design/xstage.sv
design/xversat.sv
tb/tb_xversat.sv

//--- tb/tb_xversat_model.svh
`ifndef TB_XVERSAT_MODEL_SVH
`define TB_XVERSAT_MODEL_SVH

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd45639;

// expected contents and configuration of every stage
word_t   mem_m   [N_STAGE][MEM_DEPTH];
int      src_m   [N_STAGE];
int      dst_m   [N_STAGE];
int      cnt_m   [N_STAGE];
alu_op_t op_m    [N_STAGE];
logic    flow_m  [N_STAGE];
word_t   const_m [N_STAGE];

function automatic logic lfsr_bit();
   logic fb;
   fb = lfsr_state[0];
   lfsr_state = lfsr_state >> 1;
   if (fb) begin
      lfsr_state = lfsr_state ^ 16'hB400;
   end
   return fb;
endfunction

// one lfsr step per bit taken
function automatic word_t rand_bits(input int n);
   word_t r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      r = {r[DATA_W-2:0], lfsr_bit()};
   end
   return r;
endfunction

// read-back keeps only the field width
function automatic word_t field_value(input int idx, input word_t w);
   case (idx)
      0, 1:    return w & 32'h1f;
      2:       return w & 32'h3f;
      3:       return w & 32'h7;
      4:       return w & 32'h1;
      5:       return w;
      default: return '0;
   endcase
endfunction

function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
   case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MAX:  return (a > b) ? a : b;
      OP_MIN:  return (a < b) ? a : b;
      default: return a;
   endcase
endfunction

// step k of stage s pairs its source word with the constant
// or with step k of the previous stage in the ring
task automatic apply_run();
   word_t snap [N_STAGE][MEM_DEPTH];
   word_t b;
   int    p;
   snap = mem_m;
   for (int s = 0; s < N_STAGE; s++) begin
      p = (s + N_STAGE - 1) % N_STAGE;
      for (int k = 0; k < cnt_m[s]; k++) begin
         b = flow_m[s] ? snap[p][(src_m[p] + k) % MEM_DEPTH] : const_m[s];
         mem_m[s][(dst_m[s] + k) % MEM_DEPTH] =
            alu_ref(op_m[s], snap[s][(src_m[s] + k) % MEM_DEPTH], b);
      end
   end
endtask

`endif

//--- tb/tb_xversat.sv
`timescale 1ns/1ns

module tb_xversat;
   import versat_geom_pkg::*;
   import versat_fu_pkg::*;

   localparam int         TIMEOUT  = 100;
   localparam host_addr_t RUN_ADDR = host_addr_t'(1 << RUN_BIT);

   logic       clk, arst_n;
   logic       ctr_valid, ctr_we, data_valid, data_we;
   host_addr_t ctr_addr, data_addr;
   word_t      ctr_data_in, ctr_data_out, data_data_in, data_data_out;

   `include "tb_xversat_model.svh"

   xversat DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
         $display("tests failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s", what);
      $display("tests failed");
      $fatal(1, "stopping on timeout");
   endtask

   function automatic host_addr_t stage_addr(input int s, input int idx);
      return host_addr_t'((s << MEM_ADDR_W) | idx);
   endfunction

   // bus tasks start and end on a falling edge
   task automatic ctr_write(input host_addr_t addr, input word_t d);
      ctr_valid   = 1'b1;
      ctr_we      = 1'b1;
      ctr_addr    = addr;
      ctr_data_in = d;
      @(negedge clk);
      ctr_valid = 1'b0;
      ctr_we    = 1'b0;
   endtask

   // combinational read sampled in the low phase
   task automatic ctr_read(input host_addr_t addr, output word_t d);
      ctr_valid = 1'b1;
      ctr_we    = 1'b0;
      ctr_addr  = addr;
      #1;
      d = ctr_data_out;
      @(negedge clk);
      ctr_valid = 1'b0;
   endtask

   task automatic data_write(input int s, input int a, input word_t d);
      data_valid   = 1'b1;
      data_we      = 1'b1;
      data_addr    = stage_addr(s, a);
      data_data_in = d;
      @(negedge clk);
      data_valid = 1'b0;
      data_we    = 1'b0;
   endtask

   // read data arrives one cycle after data_valid
   task automatic data_read(input int s, input int a, output word_t d);
      data_valid = 1'b1;
      data_we    = 1'b0;
      data_addr  = stage_addr(s, a);
      @(negedge clk);
      data_valid = 1'b0;
      d = data_data_out;
   endtask

   task automatic check_memories();
      word_t d;
      for (int s = 0; s < N_STAGE; s++) begin
         for (int a = 0; a < MEM_DEPTH; a++) begin
            data_read(s, a, d);
            check_value($sformatf("data_data_out stage %0d word %0d", s, a), d, mem_m[s][a]);
         end
      end
   endtask

   task automatic configure_stage(input int s, input int src, input int dst, input int cnt,
                                  input int op, input bit flow, input word_t cval);
      ctr_write(stage_addr(s, REG_SRC), word_t'(src));
      ctr_write(stage_addr(s, REG_DST), word_t'(dst));
      ctr_write(stage_addr(s, REG_COUNT), word_t'(cnt));
      ctr_write(stage_addr(s, REG_OP), word_t'(op));
      ctr_write(stage_addr(s, REG_FLOW), word_t'(flow));
      ctr_write(stage_addr(s, REG_CONST), cval);
      src_m[s]   = src;
      dst_m[s]   = dst;
      cnt_m[s]   = cnt;
      op_m[s]    = alu_op_t'(op);
      flow_m[s]  = flow;
      const_m[s] = cval;
   endtask

   // sources in the low half and destinations in the high half
   task automatic pick_windows(input int cnt, output int src, output int dst);
      src = int'(rand_bits(5)) % (MEM_DEPTH / 2 - cnt + 1);
      dst = MEM_DEPTH / 2 + int'(rand_bits(5)) % (MEM_DEPTH / 2 - cnt + 1);
   endtask

   task automatic wait_done();
      word_t d;
      int    n;
      d = '0;
      n = 0;
      while (d == '0 && n < TIMEOUT) begin
         ctr_read(RUN_ADDR, d);
         n++;
      end
      if (d == '0) begin
         report_timeout("done flag never returned after a run");
      end else begin
         check_value("ctr_data_out done after run", d, 32'd1);
      end
   endtask

   task automatic run_and_check();
      word_t d;
      ctr_write(RUN_ADDR, '0);
      if (cnt_m[0] != 0 || cnt_m[1] != 0) begin
         ctr_read(RUN_ADDR, d);
         check_value("ctr_data_out done after start", d, '0);
      end
      wait_done();
      apply_run();
      check_memories();
   endtask

   initial begin
      word_t d;
      word_t w;
      int    s_idx;
      int    a;
      int    cnt;
      int    src [N_STAGE];
      int    dst [N_STAGE];

      arst_n       = 1'b0;
      ctr_valid    = 1'b0;
      ctr_we       = 1'b0;
      ctr_addr     = '0;
      ctr_data_in  = '0;
      data_valid   = 1'b0;
      data_we      = 1'b0;
      data_addr    = '0;
      data_data_in = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // idle with cleared configuration
      ctr_read(RUN_ADDR, d);
      check_value("ctr_data_out done after reset", d, 32'd1);
      for (int s = 0; s < N_STAGE; s++) begin
         for (int i = 0; i < 8; i++) begin
            ctr_read(stage_addr(s, i), d);
            check_value($sformatf("ctr_data_out reset conf %0d/%0d", s, i), d, '0);
         end
      end

      for (int s = 0; s < N_STAGE; s++) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            w = rand_bits(DATA_W);
            data_write(s, i, w);
            mem_m[s][i] = w;
         end
      end
      repeat (16) begin
         s_idx = int'(rand_bits(STAGE_W));
         a     = int'(rand_bits(MEM_ADDR_W));
         w     = rand_bits(DATA_W);
         data_write(s_idx, a, w);
         mem_m[s_idx][a] = w;
      end
      check_memories();

      for (int s = 0; s < N_STAGE; s++) begin
         for (int i = 0; i < 8; i++) begin
            w = rand_bits(DATA_W);
            ctr_write(stage_addr(s, i), w);
            ctr_read(stage_addr(s, i), d);
            check_value($sformatf("ctr_data_out conf %0d/%0d", s, i), d, field_value(i, w));
         end
      end

      // constant operand with every opcode
      for (int op = 0; op < 8; op++) begin
         for (int s = 0; s < N_STAGE; s++) begin
            cnt = 1 + int'(rand_bits(4));
            pick_windows(cnt, src[s], dst[s]);
            configure_stage(s, src[s], dst[s], cnt, (op + 3 * s) % 8, 1'b0, rand_bits(DATA_W));
         end
         run_and_check();
      end

      // ring operand with equal counts so the stages stay in step
      // pass ignores the operand, so it is left out here
      cnt = 1 + int'(rand_bits(4));
      for (int s = 0; s < N_STAGE; s++) begin
         pick_windows(cnt, src[s], dst[s]);
         configure_stage(s, src[s], dst[s], cnt, int'(rand_bits(3)) % 7, 1'b1,
                         rand_bits(DATA_W));
      end
      run_and_check();

      // second run reads back the previous results
      for (int s = 0; s < N_STAGE; s++) begin
         configure_stage(s, dst[s], src[s], cnt, int'(op_m[s]), 1'b1, const_m[s]);
      end
      run_and_check();

      $display("all tests passed");
      $finish;
   end

endmodule

//--- design/xversat.sv
`timescale 1ns/1ns

module xversat (
   input  logic                        clk,
   input  logic                        arst_n,
   // control port
   input  logic                        ctr_valid,
   input  logic                        ctr_we,
   input  versat_geom_pkg::host_addr_t ctr_addr,
   input  versat_geom_pkg::word_t      ctr_data_in,
   output versat_geom_pkg::word_t      ctr_data_out,
   // data port
   input  logic                        data_valid,
   input  logic                        data_we,
   input  versat_geom_pkg::host_addr_t data_addr,
   input  versat_geom_pkg::word_t      data_data_in,
   output versat_geom_pkg::word_t      data_data_out
);
   import versat_geom_pkg::*;

   stage_sel_t         ctr_sel;
   stage_sel_t         data_sel;
   stage_sel_t         data_sel_q;
   logic               ctr_run;
   logic               run_pulse;
   logic [N_STAGE-1:0] stage_conf_valid;
   logic [N_STAGE-1:0] stage_mem_valid;
   logic [N_STAGE-1:0] stage_done;
   word_t              stage_conf_rdata [N_STAGE];
   word_t              stage_mem_rdata  [N_STAGE];
   word_t              stage_flow       [N_STAGE];

   assign ctr_run  = ctr_addr[RUN_BIT];
   assign ctr_sel  = ctr_addr[MEM_ADDR_W +: STAGE_W];
   assign data_sel = data_addr[MEM_ADDR_W +: STAGE_W];

   // a single write to the run address starts every stage
   assign run_pulse = ctr_valid & ctr_we & ctr_run;

   // stage selects for both ports
   always_comb begin
      for (int j = 0; j < N_STAGE; j++) begin
         stage_conf_valid[j] = ctr_valid & ~ctr_run & (ctr_sel == stage_sel_t'(j));
         stage_mem_valid[j]  = data_valid & (data_sel == stage_sel_t'(j));
      end
   end

   // control read-back, run/done address gives the AND of all done flags
   always_comb begin
      if (ctr_run) begin
         ctr_data_out = word_t'(&stage_done);
      end else if (ctr_valid) begin
         ctr_data_out = stage_conf_rdata[ctr_sel];
      end else begin
         ctr_data_out = '0;
      end
   end

   // memory read is registered, so keep the stage index for one cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_sel_q <= '0;
      end else if (data_valid) begin
         data_sel_q <= data_sel;
      end
   end

   assign data_data_out = stage_mem_rdata[data_sel_q];

   for (genvar i = 0; i < N_STAGE; i++) begin : g_stage
      xstage u_stage (
         .clk        (clk),
         .arst_n     (arst_n),
         .conf_valid (stage_conf_valid[i]),
         .conf_we    (ctr_we),
         .conf_idx   (ctr_addr[CONF_W-1:0]),
         .conf_wdata (ctr_data_in),
         .conf_rdata (stage_conf_rdata[i]),
         .run        (run_pulse),
         .done       (stage_done[i]),
         .mem_valid  (stage_mem_valid[i]),
         .mem_we     (data_we),
         .mem_addr   (data_addr[MEM_ADDR_W-1:0]),
         .mem_wdata  (data_data_in),
         .mem_rdata  (stage_mem_rdata[i]),
         // ring: stage 0 closes the loop from the last stage
         .flow_in    (stage_flow[(i + N_STAGE - 1) % N_STAGE]),
         .flow_out   (stage_flow[i])
      );
   end

endmodule

//--- design/xstage.sv
`timescale 1ns/1ns

module xstage (
   input  logic                                 clk,
   input  logic                                 arst_n,
   // configuration access
   input  logic                                 conf_valid,
   input  logic                                 conf_we,
   input  logic [versat_geom_pkg::CONF_W-1:0]   conf_idx,
   input  versat_geom_pkg::word_t               conf_wdata,
   output versat_geom_pkg::word_t               conf_rdata,
   // run control
   input  logic                                 run,
   output logic                                 done,
   // memory access from the host
   input  logic                                 mem_valid,
   input  logic                                 mem_we,
   input  versat_geom_pkg::mem_addr_t           mem_addr,
   input  versat_geom_pkg::word_t               mem_wdata,
   output versat_geom_pkg::word_t               mem_rdata,
   // ring
   input  versat_geom_pkg::word_t               flow_in,
   output versat_geom_pkg::word_t               flow_out
);
   import versat_geom_pkg::*;
   import versat_fu_pkg::*;

   stage_conf_t conf;
   logic        busy;
   logic        step_en;
   logic        wr_en;
   logic        last;
   count_t      step;
   mem_addr_t   step_d1;
   mem_addr_t   step_d2;
   mem_addr_t   src_addr;
   mem_addr_t   dst_addr;
   logic        a_en;
   logic        a_we;
   mem_addr_t   a_addr;
   word_t       a_rdata;
   word_t       operand;
   word_t       alu_y;

   xconf_regs u_conf (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (conf_valid),
      .we     (conf_we),
      .idx    (conf_idx),
      .wdata  (conf_wdata),
      .rdata  (conf_rdata),
      .conf   (conf)
   );

   xrun_ctrl u_ctrl (
      .clk     (clk),
      .arst_n  (arst_n),
      .run     (run),
      .count   (conf.count),
      .last    (last),
      .busy    (busy),
      .done    (done),
      .step_en (step_en),
      .wr_en   (wr_en)
   );

   xaddr_gen u_agen (
      .clk     (clk),
      .arst_n  (arst_n),
      .clear   (run),
      .step_en (step_en),
      .count   (conf.count),
      .step    (step),
      .last    (last)
   );

   // step follows the word through the read and ALU registers
   always_ff @(posedge clk) begin
      step_d1 <= step[MEM_ADDR_W-1:0];
      step_d2 <= step_d1;
   end

   assign src_addr = conf.src_start + step[MEM_ADDR_W-1:0];
   assign dst_addr = conf.dst_start + step_d2;

   // port A belongs to the host unless a run is in progress
   assign a_en   = busy ? step_en : mem_valid;
   assign a_we   = busy ? 1'b0 : mem_we;
   assign a_addr = busy ? src_addr : mem_addr;

   xmem u_mem (
      .clk     (clk),
      .a_en    (a_en),
      .a_we    (a_we),
      .a_addr  (a_addr),
      .a_wdata (mem_wdata),
      .a_rdata (a_rdata),
      .b_we    (wr_en),
      .b_addr  (dst_addr),
      .b_wdata (alu_y)
   );

   assign mem_rdata = a_rdata;
   assign flow_out  = a_rdata;

   assign operand = conf.use_flow ? flow_in : conf.const_val;

   xalu u_alu (
      .clk    (clk),
      .arst_n (arst_n),
      .op     (conf.op),
      .a      (a_rdata),
      .b      (operand),
      .y      (alu_y)
   );

endmodule

//--- design/xconf_regs.sv
`timescale 1ns/1ns

module xconf_regs (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               valid,
   input  logic                               we,
   input  logic [versat_geom_pkg::CONF_W-1:0] idx,
   input  versat_geom_pkg::word_t             wdata,
   output versat_geom_pkg::word_t             rdata,
   output versat_fu_pkg::stage_conf_t         conf
);
   import versat_geom_pkg::*;
   import versat_fu_pkg::*;

   // each field keeps only its own width of the written word
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         conf <= '0;
      end else if (valid && we) begin
         case (idx)
            REG_SRC:   conf.src_start <= wdata[MEM_ADDR_W-1:0];
            REG_DST:   conf.dst_start <= wdata[MEM_ADDR_W-1:0];
            REG_COUNT: conf.count     <= wdata[COUNT_W-1:0];
            REG_OP:    conf.op        <= alu_op_t'(wdata[$bits(alu_op_t)-1:0]);
            REG_FLOW:  conf.use_flow  <= wdata[0];
            REG_CONST: conf.const_val <= wdata;
            default: begin
            end
         endcase
      end
   end

   // read-back zero-extends, unused indices give zero
   always_comb begin
      case (idx)
         REG_SRC:   rdata = word_t'(conf.src_start);
         REG_DST:   rdata = word_t'(conf.dst_start);
         REG_COUNT: rdata = word_t'(conf.count);
         REG_OP:    rdata = word_t'(conf.op);
         REG_FLOW:  rdata = word_t'(conf.use_flow);
         REG_CONST: rdata = conf.const_val;
         default:   rdata = '0;
      endcase
   end

endmodule

//--- design/xrun_ctrl.sv
`timescale 1ns/1ns

module xrun_ctrl (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    run,
   input  versat_geom_pkg::count_t count,
   input  logic                    last,
   output logic                    busy,
   output logic                    done,
   output logic                    step_en,
   output logic                    wr_en
);
   import versat_fu_pkg::*;

   run_state_t state;
   run_state_t state_nxt;
   // [0] read data valid, [1] ALU result valid
   logic [1:0] vld;

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (run) begin
               state_nxt = (count == '0) ? S_DRAIN : S_RUN;
            end
         end
         S_RUN: begin
            if (last) begin
               state_nxt = S_DRAIN;
            end
         end
         S_DRAIN: begin
            // wait for the last write to leave the pipe
            if (vld == 2'b00) begin
               state_nxt = S_IDLE;
            end
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= S_IDLE;
         vld   <= 2'b00;
      end else begin
         state <= state_nxt;
         vld   <= {vld[0], step_en};
      end
   end

   assign step_en = (state == S_RUN);
   assign wr_en   = vld[1];
   assign done    = (state == S_IDLE);
   assign busy    = ~done;

endmodule

//--- design/xaddr_gen.sv
`timescale 1ns/1ns

module xaddr_gen (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    clear,
   input  logic                    step_en,
   input  versat_geom_pkg::count_t count,
   output versat_geom_pkg::count_t step,
   output logic                    last
);
   import versat_geom_pkg::*;

   // restarts from zero on every run pulse
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step <= '0;
      end else if (clear) begin
         step <= '0;
      end else if (step_en) begin
         step <= step + 1'b1;
      end
   end

   // never matches for count zero, the FSM skips RUN then
   assign last = (step == count_t'(count - 1'b1));

endmodule

//--- design/xalu.sv
`timescale 1ns/1ns

module xalu (
   input  logic                   clk,
   input  logic                   arst_n,
   input  versat_fu_pkg::alu_op_t op,
   input  versat_geom_pkg::word_t a,
   input  versat_geom_pkg::word_t b,
   output versat_geom_pkg::word_t y
);
   import versat_geom_pkg::*;
   import versat_fu_pkg::*;

   word_t res;

   // a is the memory word, b the constant or flow operand
   always_comb begin
      case (op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         OP_MAX:  res = (a > b) ? a : b;
         OP_MIN:  res = (a < b) ? a : b;
         // plain copy of the source word
         OP_PASS: res = a;
         default: res = a;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         y <= '0;
      end else begin
         y <= res;
      end
   end

endmodule

//--- design/xmem.sv
`timescale 1ns/1ns

module xmem (
   input  logic                       clk,
   // port A, host access or engine source read
   input  logic                       a_en,
   input  logic                       a_we,
   input  versat_geom_pkg::mem_addr_t a_addr,
   input  versat_geom_pkg::word_t     a_wdata,
   output versat_geom_pkg::word_t     a_rdata,
   // port B, engine result write
   input  logic                       b_we,
   input  versat_geom_pkg::mem_addr_t b_addr,
   input  versat_geom_pkg::word_t     b_wdata
);
   import versat_geom_pkg::*;

   word_t mem [MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (a_en) begin
         if (a_we) begin
            mem[a_addr] <= a_wdata;
         end
         // read-first on a write
         a_rdata <= mem[a_addr];
      end
      if (b_we) begin
         mem[b_addr] <= b_wdata;
      end
   end

endmodule

//--- design/versat_fu_pkg.sv
package versat_fu_pkg;

   import versat_geom_pkg::*;

   // alu opcodes, max and min compare unsigned
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_MAX  = 3'd5,
      OP_MIN  = 3'd6,
      OP_PASS = 3'd7
   } alu_op_t;

   // stage run FSM
   typedef enum logic [1:0] {
      S_IDLE  = 2'd0,
      S_RUN   = 2'd1,
      S_DRAIN = 2'd2
   } run_state_t;

   // one stage's configuration
   typedef struct packed {
      mem_addr_t src_start;
      mem_addr_t dst_start;
      count_t    count;
      alu_op_t   op;
      logic      use_flow;
      word_t     const_val;
   } stage_conf_t;

   // configuration register indices
   localparam logic [CONF_W-1:0] REG_SRC   = 3'd0;
   localparam logic [CONF_W-1:0] REG_DST   = 3'd1;
   localparam logic [CONF_W-1:0] REG_COUNT = 3'd2;
   localparam logic [CONF_W-1:0] REG_OP    = 3'd3;
   localparam logic [CONF_W-1:0] REG_FLOW  = 3'd4;
   localparam logic [CONF_W-1:0] REG_CONST = 3'd5;

endpackage

//--- design/versat_geom_pkg.sv
package versat_geom_pkg;

   // array geometry
   localparam int N_STAGE    = 2;
   localparam int STAGE_W    = 1;

   // datapath and memory
   localparam int DATA_W     = 32;
   localparam int MEM_ADDR_W = 5;
   localparam int MEM_DEPTH  = 32;
   // step counter must reach MEM_DEPTH itself
   localparam int COUNT_W    = 6;

   // host address map
   localparam int CONF_W     = 3;
   localparam int ADDR_W     = 8;
   // set for the run/done address
   localparam int RUN_BIT    = 7;

   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [ADDR_W-1:0]     host_addr_t;
   typedef logic [STAGE_W-1:0]    stage_sel_t;
   typedef logic [COUNT_W-1:0]    count_t;

endpackage
